// ==== verilog/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;

    // encodings follow the LC-3b ISA
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add  = 3'd0,
        alu_and  = 3'd1,
        alu_not  = 3'd2,
        alu_pass = 3'd3,
        alu_sll  = 3'd4,
        alu_srl  = 3'd5,
        alu_sra  = 3'd6
    } lc3b_aluop;

    // carried along the pipe with each instruction
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       load_cc;
        logic       load_regfile;
        logic       sr2mux_sel;      // 1 selects the immediate
        logic       mem_read;
        logic       mem_write;
        logic       addr1mux_sel;
        logic [1:0] addr2mux_sel;
        logic [1:0] drmux_sel;
        logic       regfilemux_sel;
        logic       memaddrmux_sel;
        logic       destmux_sel;     // 1 writes R7
        logic       sr1_needed;
        logic       sr2_needed;
    } lc3b_control_word;

endpackage : lc3b_types

`default_nettype wire

// ==== verilog/instr_latch.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_latch (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic                   fetch_valid,
    input  wire lc3b_types::lc3b_word   instr,
    input  wire lc3b_types::lc3b_word   pc,
    input  wire logic                   hold,
    output logic                        id_valid,
    output lc3b_types::lc3b_word        id_instr,
    output lc3b_types::lc3b_word        id_pc,
    output lc3b_types::lc3b_opcode      id_opcode,
    output lc3b_types::lc3b_reg         id_sr1,
    output lc3b_types::lc3b_reg         id_sr2,
    output logic                        imm_check,
    output logic                        jsr_check,
    output logic                        rshf_check
);

    import lc3b_types::*;

    logic is_store;

    // fetch register, frozen while hold is high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_valid <= 1'b0;
            id_instr <= '0;
            id_pc    <= '0;
        end else if (!hold) begin
            id_valid <= fetch_valid;
            id_instr <= instr;
            id_pc    <= pc;
        end
    end

    assign id_opcode = lc3b_opcode'(id_instr[15:12]);

    // stores read the data register from the dr field
    assign is_store = (id_opcode == op_str) || (id_opcode == op_stb) ||
                      (id_opcode == op_sti);

    assign id_sr1 = id_instr[8:6];
    assign id_sr2 = is_store ? id_instr[11:9] : id_instr[2:0];

    assign imm_check  = id_instr[5];   // also arithmetic flag for shf
    assign jsr_check  = id_instr[11];  // 1 = jsr, 0 = jsrr
    assign rshf_check = id_instr[4];   // shift direction

endmodule : instr_latch

`default_nettype wire

// ==== verilog/control_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_rom (
    input  wire lc3b_types::lc3b_opcode opcode,
    input  wire logic                   imm_check,
    input  wire logic                   jsr_check,
    input  wire logic                   rshf_check,
    output lc3b_types::lc3b_control_word ctrl
);

    import lc3b_types::*;

    always_comb begin
        // defaults, overridden per opcode below
        ctrl                = '0;
        ctrl.opcode         = opcode;
        ctrl.aluop          = alu_pass;

        case (opcode)
            op_add, op_and: begin
                ctrl.aluop          = (opcode == op_add) ? alu_add : alu_and;
                ctrl.sr1_needed     = 1'b1;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
                ctrl.drmux_sel      = 2'b11;
                ctrl.regfilemux_sel = 1'b1;
                // register form reads sr2, immediate form does not
                ctrl.sr2mux_sel     = imm_check;
                ctrl.sr2_needed     = ~imm_check;
            end

            op_not: begin
                ctrl.aluop        = alu_not;
                ctrl.sr1_needed   = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.drmux_sel    = 2'b11;
            end

            op_shf: begin
                if (!rshf_check) begin
                    ctrl.aluop = alu_sll;
                end else if (!imm_check) begin
                    ctrl.aluop = alu_srl;
                end else begin
                    ctrl.aluop = alu_sra;
                end
                ctrl.sr1_needed   = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.drmux_sel    = 2'b11;
            end

            // ldi is handled as a plain base+offset load
            op_ldr, op_ldi: begin
                ctrl.sr1_needed   = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.addr1mux_sel = 1'b1;     // base register
                ctrl.addr2mux_sel = 2'b01;    // offset6
                ctrl.drmux_sel    = 2'b01;
            end

            op_str, op_sti: begin
                ctrl.sr1_needed   = 1'b1;
                ctrl.mem_write    = 1'b1;
                ctrl.load_cc      = 1'b1;
                ctrl.addr1mux_sel = 1'b1;
                ctrl.addr2mux_sel = 2'b01;
            end

            op_ldb, op_stb: begin
                ctrl.sr1_needed = 1'b1;  // base register only
            end

            op_br: begin
                ctrl.addr2mux_sel   = 2'b10;   // pc + offset9
                ctrl.memaddrmux_sel = 1'b1;
            end

            op_lea: begin
                ctrl.addr2mux_sel   = 2'b10;
                ctrl.memaddrmux_sel = 1'b1;
                ctrl.drmux_sel      = 2'b01;
                ctrl.load_regfile   = 1'b1;
                ctrl.load_cc        = 1'b1;
            end

            op_jmp: begin
                ctrl.sr1_needed     = 1'b1;
                ctrl.addr1mux_sel   = 1'b1;
                ctrl.addr2mux_sel   = 2'b00;
                ctrl.memaddrmux_sel = 1'b1;
            end

            op_jsr: begin
                ctrl.destmux_sel = 1'b1;           // link goes to R7
                ctrl.sr1_needed  = ~jsr_check;     // jsrr jumps through base reg
            end

            op_trap: begin
                ctrl.destmux_sel = 1'b1;
            end

            default: begin
                ctrl = '0;   // rti and anything unexpected
            end
        endcase
    end

endmodule : control_rom

`default_nettype wire

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire logic                 load,
    input  wire lc3b_types::lc3b_reg  dest,
    input  wire lc3b_types::lc3b_word data_in,
    input  wire lc3b_types::lc3b_reg  sr1,
    input  wire lc3b_types::lc3b_reg  sr2,
    output lc3b_types::lc3b_word      sr1_data,
    output lc3b_types::lc3b_word      sr2_data
);

    import lc3b_types::*;

    lc3b_word regs [8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (load) begin
            regs[dest] <= data_in;
        end
    end

    // write-through so decode sees the value being written this cycle
    always_comb begin
        if (load && (dest == sr1)) begin
            sr1_data = data_in;
        end else begin
            sr1_data = regs[sr1];
        end

        if (load && (dest == sr2)) begin
            sr2_data = data_in;
        end else begin
            sr2_data = regs[sr2];
        end
    end

endmodule : regfile

`default_nettype wire

// ==== verilog/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  wire logic                         ex_stall,
    input  wire logic                         id_valid,
    input  wire lc3b_types::lc3b_word         id_instr,
    input  wire lc3b_types::lc3b_word         id_pc,
    input  wire lc3b_types::lc3b_reg          id_sr1,
    input  wire lc3b_types::lc3b_reg          id_sr2,
    input  wire lc3b_types::lc3b_control_word ctrl,
    input  wire lc3b_types::lc3b_word         sr1_data,
    input  wire lc3b_types::lc3b_word         sr2_data,
    output logic                              decode_stall,
    output logic                              ex_valid,
    output lc3b_types::lc3b_control_word      ex_ctrl,
    output lc3b_types::lc3b_word              ex_pc,
    output lc3b_types::lc3b_word              ex_instr,
    output lc3b_types::lc3b_word              ex_sr1_data,
    output lc3b_types::lc3b_word              ex_sr2_data,
    output lc3b_types::lc3b_reg               ex_dest
);

    import lc3b_types::*;

    lc3b_reg dest_sel;
    logic    ex_is_load;
    logic    src_match;
    logic    load_use;

    // jsr and trap link into R7
    assign dest_sel = ctrl.destmux_sel ? 3'd7 : id_instr[11:9];

    assign ex_is_load = ex_valid && ex_ctrl.mem_read && ex_ctrl.load_regfile;

    assign src_match = (ctrl.sr1_needed && (ex_dest == id_sr1)) ||
                       (ctrl.sr2_needed && (ex_dest == id_sr2));

    assign load_use = ex_is_load && src_match;

    // back-pressure wins, the stall is only raised when the pipe moves
    assign decode_stall = load_use && !ex_stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
            ex_ctrl  <= '0;
            ex_dest  <= '0;
        end else if (!ex_stall) begin
            if (load_use || !id_valid) begin
                // bubble, also for an empty decode slot
                ex_valid <= 1'b0;
                ex_ctrl  <= '0;
                ex_dest  <= '0;
            end else begin
                ex_valid <= 1'b1;
                ex_ctrl  <= ctrl;
                ex_dest  <= dest_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ex_stall) begin
            ex_pc       <= id_pc;
            ex_instr    <= id_instr;
            ex_sr1_data <= sr1_data;
            ex_sr2_data <= sr2_data;
        end
    end

endmodule : id_ex_reg

`default_nettype wire

// ==== verilog/lc3b_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_decode (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic                    fetch_valid,
    input  wire lc3b_types::lc3b_word    instr,
    input  wire lc3b_types::lc3b_word    pc,
    input  wire logic                    ex_stall,
    input  wire logic                    wb_load,
    input  wire lc3b_types::lc3b_reg     wb_dest,
    input  wire lc3b_types::lc3b_word    wb_data,
    output logic                         decode_stall,
    output logic                         ex_valid,
    output lc3b_types::lc3b_control_word ex_ctrl,
    output lc3b_types::lc3b_word         ex_pc,
    output lc3b_types::lc3b_word         ex_instr,
    output lc3b_types::lc3b_word         ex_sr1_data,
    output lc3b_types::lc3b_word         ex_sr2_data,
    output lc3b_types::lc3b_reg          ex_dest
);

    import lc3b_types::*;

    logic             hold;
    logic             id_valid;
    lc3b_word         id_instr;
    lc3b_word         id_pc;
    lc3b_opcode       id_opcode;
    lc3b_reg          id_sr1;
    lc3b_reg          id_sr2;
    logic             imm_check;
    logic             jsr_check;
    logic             rshf_check;
    lc3b_control_word ctrl;
    lc3b_word         sr1_data;
    lc3b_word         sr2_data;

    assign hold = decode_stall | ex_stall;

    instr_latch u_instr_latch (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_valid (fetch_valid),
        .instr       (instr),
        .pc          (pc),
        .hold        (hold),
        .id_valid    (id_valid),
        .id_instr    (id_instr),
        .id_pc       (id_pc),
        .id_opcode   (id_opcode),
        .id_sr1      (id_sr1),
        .id_sr2      (id_sr2),
        .imm_check   (imm_check),
        .jsr_check   (jsr_check),
        .rshf_check  (rshf_check)
    );

    control_rom u_control_rom (
        .opcode     (id_opcode),
        .imm_check  (imm_check),
        .jsr_check  (jsr_check),
        .rshf_check (rshf_check),
        .ctrl       (ctrl)
    );

    regfile u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .load     (wb_load),
        .dest     (wb_dest),
        .data_in  (wb_data),
        .sr1      (id_sr1),
        .sr2      (id_sr2),
        .sr1_data (sr1_data),
        .sr2_data (sr2_data)
    );

    id_ex_reg u_id_ex_reg (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex_stall     (ex_stall),
        .id_valid     (id_valid),
        .id_instr     (id_instr),
        .id_pc        (id_pc),
        .id_sr1       (id_sr1),
        .id_sr2       (id_sr2),
        .ctrl         (ctrl),
        .sr1_data     (sr1_data),
        .sr2_data     (sr2_data),
        .decode_stall (decode_stall),
        .ex_valid     (ex_valid),
        .ex_ctrl      (ex_ctrl),
        .ex_pc        (ex_pc),
        .ex_instr     (ex_instr),
        .ex_sr1_data  (ex_sr1_data),
        .ex_sr2_data  (ex_sr2_data),
        .ex_dest      (ex_dest)
    );

endmodule : lc3b_decode

`default_nettype wire

// ==== verif/tb_lc3b_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lc3b_decode;

    import lc3b_types::*;

    localparam int NUM_LINES    = 33;
    localparam int NUM_COLS     = 13;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int WATCHDOG_NS  = (NUM_LINES + RESET_CYCLES + 10) * CLK_PERIOD;

    logic             clk;
    logic             arst_n;
    logic             fetch_valid;
    lc3b_word         instr;
    lc3b_word         pc;
    logic             ex_stall;
    logic             wb_load;
    lc3b_reg          wb_dest;
    lc3b_word         wb_data;
    logic             decode_stall;
    logic             ex_valid;
    lc3b_control_word ex_ctrl;
    lc3b_word         ex_pc;
    lc3b_word         ex_instr;
    lc3b_word         ex_sr1_data;
    lc3b_word         ex_sr2_data;
    lc3b_reg          ex_dest;

    logic [31:0] stim [0:NUM_LINES*NUM_COLS-1];   // one row of NUM_COLS words per cycle
    int          errors;

    lc3b_word    model_id_instr;   // what the decode slot should hold
    lc3b_word    model_id_pc;
    lc3b_word    model_ex_instr;
    lc3b_word    model_ex_pc;
    logic        prev_stall;

    lc3b_decode u_lc3b_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_valid  (fetch_valid),
        .instr        (instr),
        .pc           (pc),
        .ex_stall     (ex_stall),
        .wb_load      (wb_load),
        .wb_dest      (wb_dest),
        .wb_data      (wb_data),
        .decode_stall (decode_stall),
        .ex_valid     (ex_valid),
        .ex_ctrl      (ex_ctrl),
        .ex_pc        (ex_pc),
        .ex_instr     (ex_instr),
        .ex_sr1_data  (ex_sr1_data),
        .ex_sr2_data  (ex_sr2_data),
        .ex_dest      (ex_dest)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic compare_value(input int line, input string name,
                                 input logic [31:0] actual, input logic [31:0] expected);
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED time %0t line %0d %s expected %0h actual %0h",
                     $time, line, name, expected, actual);
        end
    endtask

    task automatic apply_line(input int line);
        int base;
        base        = line * NUM_COLS;
        fetch_valid = stim[base][0];
        instr       = stim[base + 1][15:0];
        pc          = stim[base + 2][15:0];
        ex_stall    = stim[base + 3][0];
        wb_load     = stim[base + 4][0];
        wb_dest     = stim[base + 5][2:0];
        wb_data     = stim[base + 6][15:0];
    endtask

    // instruction and pc expected behind the coming edge
    task automatic track_pipeline(input int line);
        int   base;
        logic hold;
        base = line * NUM_COLS;
        hold = stim[base + 3][0] || prev_stall;
        if (!stim[base + 3][0]) begin
            model_ex_instr = model_id_instr;
            model_ex_pc    = model_id_pc;
        end
        if (!hold) begin
            model_id_instr = stim[base + 1][15:0];
            model_id_pc    = stim[base + 2][15:0];
        end
        prev_stall = stim[base + 12][0];
    endtask

    task automatic check_line(input int line);
        int base;
        base = line * NUM_COLS;
        compare_value(line, "ex_valid", ex_valid, stim[base + 7]);
        compare_value(line, "ex_ctrl", ex_ctrl, stim[base + 8]);
        compare_value(line, "ex_dest", ex_dest, stim[base + 9]);
        // operands only matter behind a valid item
        if (stim[base + 7][0]) begin
            compare_value(line, "ex_sr1_data", ex_sr1_data, stim[base + 10]);
            compare_value(line, "ex_sr2_data", ex_sr2_data, stim[base + 11]);
            compare_value(line, "ex_instr", ex_instr, model_ex_instr);
            compare_value(line, "ex_pc", ex_pc, model_ex_pc);
        end
        compare_value(line, "decode_stall", decode_stall, stim[base + 12]);
    endtask

    initial begin
        errors         = 0;
        arst_n         = 1'b0;
        fetch_valid    = 1'b0;
        instr          = '0;
        pc             = '0;
        ex_stall       = 1'b0;
        wb_load        = 1'b0;
        wb_dest        = '0;
        wb_data        = '0;
        model_id_instr = '0;
        model_id_pc    = '0;
        model_ex_instr = '0;
        model_ex_pc    = '0;
        prev_stall     = 1'b0;

        $readmemh("verif/decode_stimulus.txt", stim);
        if ($isunknown(stim[NUM_LINES*NUM_COLS-1])) begin
            errors++;
            $display("stimulus file is missing or has fewer than %0d rows", NUM_LINES);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // state left by reset, reported as line -1
        compare_value(-1, "id_valid", u_lc3b_decode.id_valid, 32'h0);
        compare_value(-1, "ex_valid", ex_valid, 32'h0);
        compare_value(-1, "ex_ctrl", ex_ctrl, 32'h0);
        compare_value(-1, "ex_dest", ex_dest, 32'h0);
        compare_value(-1, "decode_stall", decode_stall, 32'h0);

        for (int i = 0; i < NUM_LINES; i++) begin
            apply_line(i);
            track_pipeline(i);
            @(negedge clk);   // outputs of the row are settled by the falling edge
            check_line(i);
        end

        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // ends a run that stops making progress
    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns, the run did not complete, %0d errors so far",
                 WATCHDOG_NS, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule : tb_lc3b_decode

`default_nettype wire

// ==== verilog.f ====
verilog/lc3b_types.sv
verilog/instr_latch.sv
verilog/control_rom.sv
verilog/regfile.sv
verilog/id_ex_reg.sv
verilog/lc3b_decode.sv
verif/tb_lc3b_decode.sv

// ==== verif/decode_stimulus.txt ====
// fetch_valid instr pc ex_stall wb_load wb_dest wb_data then expected ex_valid ex_ctrl ex_dest ex_sr1_data ex_sr2_data decode_stall
// expected values are the outputs after the clock edge of the row, so an instruction shows up one row later
0 0000 0000 0 1 1 1111  0 000000 0 0000 0000 0  // reset state, write r1
0 0000 0000 0 1 2 2222  0 000000 0 0000 0000 0  // write r2
1 1842 3000 0 1 3 3333  0 000000 0 0000 0000 0  // add r4 r1 r2, write r3
1 1AE5 3002 0 0 0 0000  1 046073 4 1111 2222 0  // add r5 r3 #5
1 5C43 3004 0 0 0 0000  1 047072 5 3333 0000 0  // and r6 r1 r3
1 90BF 3006 0 0 0 0000  1 14E073 6 1111 3333 0  // not r0 r2
1 D283 3008 0 0 0 0000  1 256062 0 2222 0000 0  // lshf r1 r2 #3
1 D293 300A 0 0 0 0000  1 366062 1 2222 3333 0  // rshfl r1 r2 #3
1 D2B3 300C 0 0 0 0000  1 36E062 1 2222 3333 0  // rshfa r1 r2 #3
1 7642 300E 0 0 0 0000  1 376062 1 2222 3333 0  // str r3 r1 #2
1 B440 3010 0 0 0 0000  1 1DC682 3 1111 3333 0  // sti r2 r1 #0
1 A040 3012 0 0 0 0000  1 2DC682 2 1111 2222 0  // ldi r0 r1 #0
1 2881 3014 0 0 0 0000  1 29EAA2 0 1111 0000 0  // ldb r4 r2 #1, no hazard on r0
1 32C0 3016 0 0 0 0000  1 098002 4 2222 1111 0  // stb r1 r3 #0
1 0E04 3018 0 0 0 0000  1 0D8002 1 3333 1111 0  // brnzp +4
1 EA08 301A 0 1 7 7777  1 018108 7 0000 0000 0  // lea r5 #8, write r7
1 C1C0 301C 0 0 0 0000  1 39E128 5 0000 0000 0  // jmp r7
1 4805 301E 0 0 0 0000  1 31820A 0 7777 0000 0  // jsr +5
1 40C0 3020 0 0 0 0000  1 118004 7 0000 0000 0  // jsrr r3
1 F025 3022 0 0 0 0000  1 118006 7 3333 0000 0  // trap x25
1 8000 3024 0 0 0 0000  1 3D8004 7 0000 0000 0  // rti
1 1581 3026 0 0 0 0000  1 000000 0 0000 0000 0  // add r2 r6 r1
1 6C40 3028 0 1 6 6666  1 046073 2 6666 1111 0  // ldr r6 r1 #0, r6 bypassed into the add
1 17A1 302A 0 0 0 0000  1 19EAA2 6 1111 0000 1  // add r3 r6 #1 reads the load
1 1862 302C 0 0 0 0000  0 000000 0 0000 0000 0  // bubble, fetch held
1 1862 302C 0 0 0 0000  1 047072 3 6666 1111 0  // add r4 r1 #2 taken now
1 6A80 302E 0 0 0 0000  1 047072 4 1111 2222 0  // ldr r5 r2 #0
1 1862 3030 0 0 0 0000  1 19EAA2 5 2222 0000 0  // add r4 r1 #2 does not read r5
1 90BF 3032 1 0 0 0000  1 19EAA2 5 2222 0000 0  // ex_stall, everything holds
1 90BF 3032 1 0 0 0000  1 19EAA2 5 2222 0000 0
1 90BF 3032 0 0 0 0000  1 047072 4 1111 2222 0  // released, not r0 r2 taken
0 0000 0000 0 0 0 0000  1 256062 0 2222 7777 0
0 0000 0000 0 0 0 0000  0 000000 0 0000 0000 0
